// File: crg.f
design/crg_pkg.sv
design/rst_sync.sv
design/rst_stretch.sv
design/core_pll_decode.sv
design/dev_pll_decode.sv
design/crg_top.sv
bench/tb_clk_gen.sv
bench/crg_checker.sv
bench/tb_crg_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_crg_top
FILELIST  := crg.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL CHECKS PASSED

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_crg_top.sv
`default_nettype none

module tb_crg_top import crg_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RST_STAGES   = 3;
    localparam int RST_CNT_END  = 32;
    localparam int LAT          = 2 * RST_STAGES + RST_CNT_END;
    localparam int NUM_RESTARTS = 4;
    localparam int NUM_SAMPLES  = 200;
    // a restart is a partial count plus a full one
    localparam int NUM_SEQ      = 2 + 2 * NUM_RESTARTS;
    localparam int WATCHDOG_CYCLES = NUM_SEQ * (LAT + 10) + NUM_SAMPLES + 100;
    localparam logic [31:0] LFSR_SEED = 32'h9a4c_6fff;

    logic         sys_clk;
    logic         rst_gen;
    strap_t       strap_i;
    logic         rst_out_o;
    pll_setting_t core_pll_o;
    pll_setting_t dev_pll_o;

    logic [31:0] lfsr_q;
    logic [15:0] core_seen;
    logic [3:0]  dev_seen;
    // model count of edges since rst_gen was released
    int          rel_cnt;

    tb_clk_gen u_clk_gen (
        .sys_clk_o (sys_clk)
    );

    crg_top #(
        .RST_STAGES  (RST_STAGES),
        .RST_CNT_END (RST_CNT_END)
    ) crg_top_inst (
        .sys_clk    (sys_clk),
        .rst_gen    (rst_gen),
        .strap_i    (strap_i),
        .rst_out_o  (rst_out_o),
        .core_pll_o (core_pll_o),
        .dev_pll_o  (dev_pll_o)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val = {val[30:0], lfsr_q[0]};
        end
    endtask

    function automatic pll_setting_t bypass_model();
        pll_setting_t s;
        s.bypass   = 1'b1;
        s.refdiv   = 6'd2;
        s.fbdiv    = 12'd20;
        s.postdiv1 = 3'd1;
        s.postdiv2 = 3'd1;
        return s;
    endfunction

    function automatic pll_setting_t core_model(input logic [3:0] sel);
        pll_setting_t s;
        s = bypass_model();
        if (sel >= 4'd1 && sel <= 4'd8) begin
            s.bypass   = 1'b0;
            s.refdiv   = 6'd2;
            s.fbdiv    = 12'(4 * (int'(sel) + 4));
            s.postdiv1 = 3'd2;
            s.postdiv2 = 3'd1;
        end
        return s;
    endfunction

    function automatic pll_setting_t dev_model(input logic [1:0] sel);
        pll_setting_t s;
        s = bypass_model();
        if (sel == 2'd1) begin
            s = '{bypass: 1'b0, refdiv: 6'd4, fbdiv: 12'd30, postdiv1: 3'd5, postdiv2: 3'd1};
        end else if (sel == 2'd2) begin
            s = '{bypass: 1'b0, refdiv: 6'd2, fbdiv: 12'd24, postdiv1: 3'd3, postdiv2: 3'd2};
        end
        return s;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        fail_stop($sformatf("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                            $time, name, expected, actual));
    endtask

    always @(posedge sys_clk or negedge rst_gen) begin
        if (!rst_gen) begin
            rel_cnt <= 0;
        end else if (rel_cnt < LAT) begin
            rel_cnt <= rel_cnt + 1;
        end
    end

    // reset output against the model on every falling edge
    always @(negedge sys_clk) begin
        assert (rst_out_o == (rel_cnt == LAT))
        else value_error("rst_out_o", 32'(rel_cnt == LAT), 32'(rst_out_o));
    end

    // called right after rst_gen is released on a rising edge
    task automatic check_release();
        for (int e = 1; e <= LAT; e++) begin
            @(posedge sys_clk);
            @(negedge sys_clk);
            assert (rst_out_o == (e == LAT))
            else value_error("rst_out_o", 32'(e == LAT), 32'(rst_out_o));
        end
    endtask

    task automatic check_decoders(input int count);
        logic [31:0] r;
        strap_t      s;
        for (int i = 0; i < count; i++) begin
            draw_bits(6, r);
            s = strap_t'(r[5:0]);
            @(posedge sys_clk);
            strap_i <= s;
            @(negedge sys_clk);
            assert (core_pll_o == core_model(s.core_sel))
            else value_error("core_pll_o", 32'(core_model(s.core_sel)), 32'(core_pll_o));
            assert (dev_pll_o == dev_model(s.dev_sel))
            else value_error("dev_pll_o", 32'(dev_model(s.dev_sel)), 32'(dev_pll_o));
            core_seen[s.core_sel] = 1'b1;
            dev_seen[s.dev_sel]   = 1'b1;
        end
    endtask

    // reset has to fall with no clock edge
    task automatic pull_reset_between_edges();
        @(negedge sys_clk);
        assert (rst_out_o == 1'b1)
        else value_error("rst_out_o", 32'd1, 32'(rst_out_o));
        #2;
        rst_gen <= 1'b0;
        #1;
        assert (rst_out_o == 1'b0)
        else value_error("rst_out_o", 32'd0, 32'(rst_out_o));
    endtask

    task automatic restart_mid_count();
        logic [31:0] r;
        int          stop_edge;
        int          low_cycles;
        draw_bits(8, r);
        stop_edge = RST_STAGES + 1 + int'(r % RST_CNT_END);
        draw_bits(2, r);
        low_cycles = 1 + int'(r[1:0]);
        @(posedge sys_clk);
        rst_gen <= 1'b0;
        repeat (2) @(posedge sys_clk);
        rst_gen <= 1'b1;
        repeat (stop_edge) @(posedge sys_clk);
        rst_gen <= 1'b0;
        repeat (low_cycles) @(posedge sys_clk);
        rst_gen <= 1'b1;
        check_release();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
        fail_stop($sformatf("watchdog expired after %0d cycles, test did not finish",
                            WATCHDOG_CYCLES));
    end

    initial begin
        rst_gen   <= 1'b0;
        strap_i   <= '0;
        lfsr_q    = LFSR_SEED;
        core_seen = '0;
        dev_seen  = '0;

        repeat (3) @(posedge sys_clk);
        rst_gen <= 1'b1;
        check_release();
        check_decoders(NUM_SAMPLES / 2);

        pull_reset_between_edges();
        // decoders keep working with reset held
        check_decoders(NUM_SAMPLES / 2);
        @(posedge sys_clk);
        rst_gen <= 1'b1;
        check_release();

        for (int n = 0; n < NUM_RESTARTS; n++) begin
            restart_mid_count();
        end

        assert (dev_seen == 4'hf)
        else fail_stop("not all four device strap codes were driven");
        assert (core_seen == 16'hffff)
        else fail_stop("not every core strap code was driven");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/crg_checker.sv
`default_nettype none

module crg_checker #(
    parameter int unsigned RST_STAGES  = 3,
    parameter int unsigned RST_CNT_END = 32
) (
    input wire logic sys_clk,
    input wire logic rst_gen,
    input wire logic rst_out_i
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LAT = 2 * RST_STAGES + RST_CNT_END;

    // cycles that rst_gen has been seen high, saturating
    int high_cnt;

    always @(posedge sys_clk or negedge rst_gen) begin
        if (!rst_gen) begin
            high_cnt <= 0;
        end else if (high_cnt < LAT) begin
            high_cnt <= high_cnt + 1;
        end
    end

    a_low_in_reset: assert property (@(posedge sys_clk) !rst_gen |-> !rst_out_i)
        else $error("system reset released while board reset is low");

    a_release_latency: assert property (@(posedge sys_clk) $rose(rst_out_i) |-> (high_cnt == LAT))
        else $error("system reset released before the full stretch sequence");

    // no glitch back into reset without a board reset
    a_stays_released: assert property (@(posedge sys_clk)
        (rst_out_i && rst_gen) |=> (rst_out_i || !rst_gen))
        else $error("system reset dropped while board reset is high");

endmodule

bind crg_top crg_checker #(
    .RST_STAGES  (RST_STAGES),
    .RST_CNT_END (RST_CNT_END)
) u_crg_checker (
    .sys_clk   (sys_clk),
    .rst_gen   (rst_gen),
    .rst_out_i (rst_out_o)
);

`default_nettype wire

// File: bench/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen #(
    parameter int unsigned HALF_PERIOD_NS = 5
) (
    output logic sys_clk_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // starts low, first rising edge at one half period
    initial begin
        sys_clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) sys_clk_o = ~sys_clk_o;
        end
    end

endmodule

`default_nettype wire

// File: design/crg_top.sv
`default_nettype none

module crg_top import crg_pkg::*; #(
    parameter int unsigned RST_STAGES  = 3,
    parameter int unsigned RST_CNT_END = 32
) (
    input  wire logic   sys_clk,
    input  wire logic   rst_gen,
    input  wire strap_t strap_i,
    output logic        rst_out_o,
    output pll_setting_t core_pll_o,
    output pll_setting_t dev_pll_o
);

    // board reset, synchronized release
    logic rst_sync_n;
    // stretch counter reached its end
    logic cnt_done;

    rst_sync #(
        .RST_STAGES (RST_STAGES)
    ) u_rst_in (
        .sys_clk  (sys_clk),
        .arst_n_i (rst_gen),
        .rst_n_o  (rst_sync_n)
    );

    rst_stretch #(
        .RST_CNT_END (RST_CNT_END)
    ) u_rst_stretch (
        .sys_clk      (sys_clk),
        .rst_sync_n_i (rst_sync_n),
        .cnt_done_o   (cnt_done)
    );

    // low cnt_done drops the system reset at once
    rst_sync #(
        .RST_STAGES (RST_STAGES)
    ) u_rst_out (
        .sys_clk  (sys_clk),
        .arst_n_i (cnt_done),
        .rst_n_o  (rst_out_o)
    );

    // strap decode, no clock and no reset
    core_pll_decode u_core_pll_decode (
        .core_sel_i (strap_i.core_sel),
        .setting_o  (core_pll_o)
    );

    dev_pll_decode u_dev_pll_decode (
        .dev_sel_i (strap_i.dev_sel),
        .setting_o (dev_pll_o)
    );

endmodule

`default_nettype wire

// File: design/dev_pll_decode.sv
`default_nettype none

module dev_pll_decode import crg_pkg::*; (
    input  wire logic [DEV_SEL_W-1:0] dev_sel_i,
    output pll_setting_t              setting_o
);

    always_comb begin
        setting_o = PLL_BYPASS_SET;
        case (dev_sel_i)
            // fbdiv 30 over refdiv 4, postdiv 5
            2'd1: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(4), fbdiv: FBDIV_W'(30),
                              postdiv1: POSTDIV_W'(5), postdiv2: POSTDIV_W'(1)};
            end
            // fbdiv 24 over refdiv 2, postdiv 3 x 2
            2'd2: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(24),
                              postdiv1: POSTDIV_W'(3), postdiv2: POSTDIV_W'(2)};
            end
            // codes 0 and 3
            default: begin
                setting_o = PLL_BYPASS_SET;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/core_pll_decode.sv
`default_nettype none

module core_pll_decode import crg_pkg::*; (
    input  wire logic [CORE_SEL_W-1:0] core_sel_i,
    output pll_setting_t               setting_o
);

    // refdiv 2 and postdiv 2/1 throughout, fbdiv steps by 4
    always_comb begin
        setting_o = PLL_BYPASS_SET;
        case (core_sel_i)
            4'd1: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(20),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd2: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(24),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd3: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(28),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd4: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(32),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd5: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(36),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd6: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(40),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd7: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(44),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            4'd8: begin
                setting_o = '{bypass: 1'b0, refdiv: REFDIV_W'(2), fbdiv: FBDIV_W'(48),
                              postdiv1: POSTDIV_W'(2), postdiv2: POSTDIV_W'(1)};
            end
            // 0 and unused codes 9..15 fall back to bypass
            default: begin
                setting_o = PLL_BYPASS_SET;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/rst_stretch.sv
`default_nettype none

module rst_stretch #(
    parameter int unsigned RST_CNT_END = 32
) (
    input  wire logic sys_clk,
    input  wire logic rst_sync_n_i,
    output logic      cnt_done_o
);

    // wide enough to hold the end value itself
    localparam int unsigned CNT_W = $clog2(RST_CNT_END + 1);
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(RST_CNT_END);

    logic [CNT_W-1:0] cnt_q;

    always_ff @(posedge sys_clk or negedge rst_sync_n_i) begin
        if (!rst_sync_n_i) begin
            cnt_q <= '0;
        end else if (cnt_q != CNT_END) begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    // saturates, so stays high until the next clear
    assign cnt_done_o = (cnt_q == CNT_END);

endmodule

`default_nettype wire

// File: design/rst_sync.sv
`default_nettype none

module rst_sync #(
    parameter int unsigned RST_STAGES = 3
) (
    input  wire logic sys_clk,
    input  wire logic arst_n_i,
    output logic      rst_n_o
);

    // chain of flops, clears at once and fills with ones
    logic [RST_STAGES-1:0] sync_q;

    always_ff @(posedge sys_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_q <= '0;
        end else begin
            // stage 0 takes the one, the rest shift up
            sync_q <= (sync_q << 1) | RST_STAGES'(1);
        end
    end

    // release after RST_STAGES edges
    assign rst_n_o = sync_q[RST_STAGES-1];

endmodule

`default_nettype wire

// File: design/crg_pkg.sv
`default_nettype none

package crg_pkg;

    // strap field widths
    localparam int unsigned CORE_SEL_W = 4;
    localparam int unsigned DEV_SEL_W  = 2;

    // pll setting field widths
    localparam int unsigned REFDIV_W  = 6;
    localparam int unsigned FBDIV_W   = 12;
    localparam int unsigned POSTDIV_W = 3;

    // one pll programming word
    // fref / refdiv * fbdiv / (postdiv1 * postdiv2) when not bypassed
    typedef struct packed {
        logic                 bypass;
        logic [REFDIV_W-1:0]  refdiv;
        logic [FBDIV_W-1:0]   fbdiv;
        logic [POSTDIV_W-1:0] postdiv1;
        logic [POSTDIV_W-1:0] postdiv2;
    } pll_setting_t;

    // board straps, device pll select sits above core pll select
    typedef struct packed {
        logic [DEV_SEL_W-1:0]  dev_sel;
        logic [CORE_SEL_W-1:0] core_sel;
    } strap_t;

    // reference clock passed straight through
    // divider fields still hold a legal lock setting
    localparam pll_setting_t PLL_BYPASS_SET = '{
        bypass:   1'b1,
        refdiv:   REFDIV_W'(2),
        fbdiv:    FBDIV_W'(20),
        postdiv1: POSTDIV_W'(1),
        postdiv2: POSTDIV_W'(1)
    };

endpackage

`default_nettype wire
